// File: hdl/sram_test_settings.svh
`ifndef SRAM_TEST_SETTINGS_SVH
`define SRAM_TEST_SETTINGS_SVH

// SRAM macro geometry

// Word address width, 256 words per macro
`define ADDR_SIZE 8

// Data word width
`define DATA_SIZE 32

// One write mask bit per byte lane
`define WMASK_SIZE 4

// Test bank size

// Number of SRAM macros behind the decoder
`define MAX_CHIPS 4

// Chip select field width, enough to name every macro
`define SELECT_SIZE 2

// Instruction register width
// chip select plus two ports of addr, din, csb, web and wmask
`define TOTAL_SIZE 94

`endif

// File: hdl/sram_port_pkg.sv
`include "sram_test_settings.svh"

package sram_port_pkg;

   // Word address into one macro
   typedef logic [`ADDR_SIZE-1:0] addr_t;

   // One data word, read or write
   typedef logic [`DATA_SIZE-1:0] data_t;

   // Byte lane write enables, 1 means the lane is written
   typedef logic [`WMASK_SIZE-1:0] wmask_t;

   // Request on one SRAM port
   // Field order matches the instruction register bit order
   typedef struct packed {
      addr_t  addr;
      data_t  din;
      logic   csb;    // Port select, active low
      logic   web;    // Write enable, active low
      wmask_t wmask;
   } sram_req_t;

endpackage

// File: hdl/sram_test_pkg.sv
`include "sram_test_settings.svh"

package sram_test_pkg;

   import sram_port_pkg::*;

   // Index of the macro under test
   typedef logic [`SELECT_SIZE-1:0] chip_sel_t;

   // Full test instruction, exactly as held in the register
   // Bit 93 is chip_sel MSB and leaves gpio_out first during a scan
   typedef struct packed {
      chip_sel_t chip_sel;
      sram_req_t port0;
      sram_req_t port1;
   } instr_t;

   // Which control pins are obeyed, as set by in_select
   typedef enum logic {
      SRC_LA   = 1'b0,
      SRC_GPIO = 1'b1
   } ctrl_src_e;

endpackage

// File: hdl/instr_register.sv
`include "sram_test_settings.svh"

module instr_register
   import sram_port_pkg::*;
   import sram_test_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  ctrl_src_e in_select,
   input  logic      la_in_load,
   input  logic      la_sram_load,
   input  logic      gpio_in,
   input  logic      gpio_scan,
   input  logic      gpio_sram_load,
   input  instr_t    la_data_in,
   input  data_t     rd_data0,
   input  data_t     rd_data1,
   output instr_t    instr,
   output logic      gpio_out
);

   instr_t instr_q;
   instr_t capture_value;

   logic scan_en;
   logic load_en;
   logic capture_en;

   // Only the pins of the selected source take effect
   always_comb begin
      scan_en    = 1'b0;
      load_en    = 1'b0;
      capture_en = 1'b0;
      if (in_select == SRC_GPIO) begin
         scan_en    = gpio_scan;
         capture_en = gpio_sram_load;
      end else begin
         load_en    = la_in_load;
         capture_en = la_sram_load;
      end
   end

   // Read words replace the two din fields, everything else is kept
   always_comb begin
      capture_value           = instr_q;
      capture_value.port0.din = rd_data0;
      capture_value.port1.din = rd_data1;
   end

   // Scan wins over parallel load, which wins over capture
   always_ff @(posedge clk) begin
      if (!resetn) begin
         instr_q <= '0;
      end else if (scan_en) begin
         instr_q <= {instr_q[`TOTAL_SIZE-2:0], gpio_in};
      end else if (load_en) begin
         instr_q <= la_data_in;
      end else if (capture_en) begin
         instr_q <= capture_value;
      end
   end

   assign instr = instr_q;

   // Scan output is the register MSB
   assign gpio_out = instr_q[`TOTAL_SIZE-1];

endmodule

// File: hdl/port_decode.sv
`include "sram_test_settings.svh"

module port_decode
   import sram_port_pkg::*;
   import sram_test_pkg::*;
(
   input  instr_t                       instr,
   input  data_t     [`MAX_CHIPS-1:0] dout0,
   input  data_t     [`MAX_CHIPS-1:0] dout1,
   output sram_req_t [`MAX_CHIPS-1:0] req0,
   output sram_req_t [`MAX_CHIPS-1:0] req1,
   output data_t                        rd_data0,
   output data_t                        rd_data1
);

   // Address, data, web and mask fan out to every macro.
   // Only the selected macro sees the instruction's csb,
   // all others stay deselected.
   always_comb begin
      for (int i = 0; i < `MAX_CHIPS; i++) begin
         req0[i] = instr.port0;
         req1[i] = instr.port1;
         if (chip_sel_t'(i) != instr.chip_sel) begin
            req0[i].csb = 1'b1;
            req1[i].csb = 1'b1;
         end
      end
   end

   // Read words of the selected macro go back for capture
   always_comb begin
      rd_data0 = dout0[instr.chip_sel];
      rd_data1 = dout1[instr.chip_sel];
   end

endmodule

// File: hdl/sram_macro_model.sv
`include "sram_test_settings.svh"

module sram_macro_model
   import sram_port_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  sram_req_t req0,
   input  sram_req_t req1,
   output data_t     dout0,
   output data_t     dout1
);

   localparam int DEPTH     = 1 << `ADDR_SIZE;
   localparam int LANE_SIZE = `DATA_SIZE / `WMASK_SIZE;

   data_t mem [0:DEPTH-1];

   logic wr0;
   logic wr1;
   logic rd0;
   logic rd1;

   // Byte lane merge of a write into the stored word
   function automatic data_t merge_lanes(data_t old_word, data_t new_word, wmask_t mask);
      data_t result;
      result = old_word;
      for (int lane = 0; lane < `WMASK_SIZE; lane++) begin
         if (mask[lane]) begin
            result[lane*LANE_SIZE +: LANE_SIZE] = new_word[lane*LANE_SIZE +: LANE_SIZE];
         end
      end
      return result;
   endfunction

   assign wr0 = !req0.csb && !req0.web;
   assign wr1 = !req1.csb && !req1.web;
   assign rd0 = !req0.csb && req0.web;
   assign rd1 = !req1.csb && req1.web;

   // Port 1 is written first so port 0 takes a shared address
   always_ff @(posedge clk) begin
      if (wr1) begin
         mem[req1.addr] <= merge_lanes(mem[req1.addr], req1.din, req1.wmask);
      end
      if (wr0) begin
         mem[req0.addr] <= merge_lanes(mem[req0.addr], req0.din, req0.wmask);
      end
   end

   // Registered read, output holds between reads
   always_ff @(posedge clk) begin
      if (!resetn) begin
         dout0 <= '0;
         dout1 <= '0;
      end else begin
         if (rd0) begin
            dout0 <= mem[req0.addr];
         end
         if (rd1) begin
            dout1 <= mem[req1.addr];
         end
      end
   end

endmodule

// File: hdl/sram_test_top.sv
`include "sram_test_settings.svh"

module sram_test_top
   import sram_port_pkg::*;
   import sram_test_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  ctrl_src_e in_select,
   // Logic analyzer side
   input  logic      la_in_load,
   input  logic      la_sram_load,
   input  instr_t    la_data_in,
   output instr_t    la_data_out,
   // GPIO scan side
   input  logic      gpio_in,
   input  logic      gpio_scan,
   input  logic      gpio_sram_load,
   output logic      gpio_out
);

   instr_t instr;

   sram_req_t [`MAX_CHIPS-1:0] req0;
   sram_req_t [`MAX_CHIPS-1:0] req1;
   data_t     [`MAX_CHIPS-1:0] dout0;
   data_t     [`MAX_CHIPS-1:0] dout1;

   data_t rd_data0;
   data_t rd_data1;

   instr_register u_instr_register (
      .clk            (clk),
      .resetn         (resetn),
      .in_select      (in_select),
      .la_in_load     (la_in_load),
      .la_sram_load   (la_sram_load),
      .gpio_in        (gpio_in),
      .gpio_scan      (gpio_scan),
      .gpio_sram_load (gpio_sram_load),
      .la_data_in     (la_data_in),
      .rd_data0       (rd_data0),
      .rd_data1       (rd_data1),
      .instr          (instr),
      .gpio_out       (gpio_out)
   );

   port_decode u_port_decode (
      .instr    (instr),
      .dout0    (dout0),
      .dout1    (dout1),
      .req0     (req0),
      .req1     (req1),
      .rd_data0 (rd_data0),
      .rd_data1 (rd_data1)
   );

   // One macro per chip select value
   for (genvar i = 0; i < `MAX_CHIPS; i++) begin : g_chip
      sram_macro_model u_sram (
         .clk    (clk),
         .resetn (resetn),
         .req0   (req0[i]),
         .req1   (req1[i]),
         .dout0  (dout0[i]),
         .dout1  (dout1[i])
      );
   end

   assign la_data_out = instr;

endmodule

// File: testbench/sram_test_tasks.svh
// One rising edge, then the drive offset
task automatic step_clock();
   @(posedge clk);
   #1;
endtask

task automatic compare_value(string name, word_t actual, word_t expected);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
   end
endtask

// Polls la_data_out until it shows the expected register
task automatic await_register(instr_t expected, string name);
   int n;
   n = 0;
   while (la_data_out !== expected && n < WAIT_LIMIT) begin
      step_clock();
      n++;
   end
   if (la_data_out !== expected) begin
      $display("Timeout at %0t: la_data_out never showed the %s", $time, name);
   end
   compare_value(name, la_data_out, expected);
endtask

function automatic sram_req_t req_of(addr_t addr, data_t din, logic csb, logic web,
                                     wmask_t wmask);
   sram_req_t r;
   r.addr  = addr;
   r.din   = din;
   r.csb   = csb;
   r.web   = web;
   r.wmask = wmask;
   return r;
endfunction

function automatic addr_t rand_addr();
   return addr_t'($urandom_range(DEPTH - 1, 0));
endfunction

function automatic data_t rand_data();
   return data_t'($urandom());
endfunction

function automatic wmask_t rand_mask();
   return wmask_t'($urandom_range(15, 0));
endfunction

// Random fields with both ports deselected
function automatic instr_t idle_instr();
   instr_t v;
   v.chip_sel = chip_sel_t'($urandom_range(`MAX_CHIPS - 1, 0));
   v.port0    = req_of(rand_addr(), rand_data(), 1'b1, 1'b0, rand_mask());
   v.port1    = req_of(rand_addr(), rand_data(), 1'b1, 1'b0, rand_mask());
   return v;
endfunction

task automatic load_la(instr_t v);
   in_select  = SRC_LA;
   la_data_in = v;
   la_in_load = 1'b1;
   step_clock();
   la_in_load = 1'b0;
   reg_model  = v;
   await_register(v, "loaded instruction");
endtask

// Memory acts at the edge after the load
task automatic write_instr(instr_t v);
   load_la(v);
   step_clock();
   apply_writes(v);
endtask

task automatic read_and_capture(instr_t v);
   instr_t expected;
   load_la(v);
   step_clock();
   la_sram_load = 1'b1;
   step_clock();
   la_sram_load = 1'b0;
   expected  = predict_capture(v);
   reg_model = expected;
   compare_value("port0.din", word_t'(la_data_out.port0.din), word_t'(expected.port0.din));
   compare_value("port1.din", word_t'(la_data_out.port1.din), word_t'(expected.port1.din));
   compare_value("la_data_out after capture", la_data_out, expected);
endtask

// Every partial value reaches the macros, so its writes are tracked
task automatic shift_in(instr_t v);
   instr_t shifted;
   shifted   = reg_model;
   in_select = SRC_GPIO;
   gpio_scan = 1'b1;
   for (int i = `TOTAL_SIZE - 1; i >= 0; i--) begin
      gpio_in = v[i];
      apply_writes(shifted);
      step_clock();
      shifted = {shifted[`TOTAL_SIZE-2:0], v[i]};
   end
   gpio_scan = 1'b0;
   reg_model = v;
   await_register(v, "scanned instruction");
endtask

task automatic shift_out_and_check(instr_t expected);
   instr_t shifted;
   shifted   = expected;
   gpio_in   = 1'b0;
   gpio_scan = 1'b1;
   for (int i = `TOTAL_SIZE - 1; i >= 0; i--) begin
      compare_value($sformatf("gpio_out bit %0d", i), word_t'(gpio_out), word_t'(expected[i]));
      apply_writes(shifted);
      step_clock();
      shifted = {shifted[`TOTAL_SIZE-2:0], 1'b0};
   end
   gpio_scan = 1'b0;
   reg_model = shifted;
endtask

task automatic reset_values();
   compare_value("la_data_out", la_data_out, '0);
   compare_value("gpio_out", word_t'(gpio_out), '0);
endtask

task automatic parallel_load();
   instr_t first;
   instr_t ignored;
   first   = idle_instr();
   ignored = idle_instr();
   load_la(first);
   // LA load is not obeyed while the GPIO pins are in control
   in_select  = SRC_GPIO;
   la_data_in = ignored;
   la_in_load = 1'b1;
   repeat (3) step_clock();
   la_in_load = 1'b0;
   compare_value("la_data_out with GPIO selected", la_data_out, first);
endtask

task automatic full_mask_writes();
   instr_t v;
   for (int c = 0; c < `MAX_CHIPS; c++) begin
      used_addr[c][0] = rand_addr();
      used_addr[c][1] = rand_addr();
      if (used_addr[c][1] == used_addr[c][0]) begin
         used_addr[c][1][0] = ~used_addr[c][0][0];
      end
      v.chip_sel = chip_sel_t'(c);
      v.port0    = req_of(used_addr[c][0], rand_data(), 1'b0, 1'b0, '1);
      v.port1    = req_of(used_addr[c][1], rand_data(), 1'b0, 1'b0, '1);
      write_instr(v);
      v.port0 = req_of(used_addr[c][0], rand_data(), 1'b0, 1'b1, rand_mask());
      v.port1 = req_of(used_addr[c][1], rand_data(), 1'b0, 1'b1, rand_mask());
      read_and_capture(v);
   end
endtask

task automatic partial_mask_writes();
   instr_t v;
   addr_t  a;
   addr_t  b;
   int     target;
   a    = rand_addr();
   b    = a;
   b[0] = ~a[0];
   // Same two addresses on every chip get a known base word
   for (int c = 0; c < `MAX_CHIPS; c++) begin
      v.chip_sel = chip_sel_t'(c);
      v.port0    = req_of(a, rand_data(), 1'b0, 1'b0, '1);
      v.port1    = req_of(b, rand_data(), 1'b0, 1'b0, '1);
      write_instr(v);
   end
   target     = $urandom_range(`MAX_CHIPS - 1, 0);
   v.chip_sel = chip_sel_t'(target);
   v.port0    = req_of(a, rand_data(), 1'b0, 1'b0, 4'b0110);
   v.port1    = req_of(b, rand_data(), 1'b0, 1'b0, 4'b1001);
   write_instr(v);
   for (int c = 0; c < `MAX_CHIPS; c++) begin
      v.chip_sel = chip_sel_t'(c);
      v.port0    = req_of(a, rand_data(), 1'b0, 1'b1, rand_mask());
      v.port1    = req_of(b, rand_data(), 1'b0, 1'b1, rand_mask());
      read_and_capture(v);
   end
endtask

task automatic gpio_scan_path();
   instr_t v;
   instr_t expected;
   int     c;
   c          = $urandom_range(`MAX_CHIPS - 1, 0);
   v.chip_sel = chip_sel_t'(c);
   v.port0    = req_of(used_addr[c][0], rand_data(), 1'b0, 1'b1, rand_mask());
   v.port1    = req_of(used_addr[c][1], rand_data(), 1'b0, 1'b1, rand_mask());
   shift_in(v);
   // Read edge, then capture through the GPIO pin
   step_clock();
   gpio_sram_load = 1'b1;
   step_clock();
   gpio_sram_load = 1'b0;
   expected  = predict_capture(v);
   reg_model = expected;
   compare_value("la_data_out after gpio capture", la_data_out, expected);
   shift_out_and_check(expected);
endtask

// File: testbench/sram_test_tb.sv
`include "sram_test_settings.svh"

module sram_test_tb
   import sram_port_pkg::*;
   import sram_test_pkg::*;
();

   typedef logic [`TOTAL_SIZE-1:0] word_t;

   localparam int DEPTH      = 1 << `ADDR_SIZE;
   localparam int LANE       = `DATA_SIZE / `WMASK_SIZE;
   localparam int WAIT_LIMIT = 8;
   localparam int RUN_LIMIT  = 40000;

   logic      clk;
   logic      resetn;
   ctrl_src_e in_select;
   logic      la_in_load;
   logic      la_sram_load;
   instr_t    la_data_in;
   instr_t    la_data_out;
   logic      gpio_in;
   logic      gpio_scan;
   logic      gpio_sram_load;
   logic      gpio_out;

   // Expected memory contents, one array per chip
   data_t ref_mem [`MAX_CHIPS][DEPTH];

   // Expected register value, kept current by the drive tasks
   instr_t reg_model;

   // Addresses written with full masks, read again by later tests
   addr_t used_addr [`MAX_CHIPS][2];

   int error_count;
   int check_count;
   int test_count;
   int first_error;
   int first_check;

   sram_test_top u_dut (
      .clk            (clk),
      .resetn         (resetn),
      .in_select      (in_select),
      .la_in_load     (la_in_load),
      .la_sram_load   (la_sram_load),
      .la_data_in     (la_data_in),
      .la_data_out    (la_data_out),
      .gpio_in        (gpio_in),
      .gpio_scan      (gpio_scan),
      .gpio_sram_load (gpio_sram_load),
      .gpio_out       (gpio_out)
   );

   always #2 clk = ~clk;

   // Byte mask widened to one bit per data bit
   function automatic data_t lane_bits(wmask_t mask);
      data_t bits;
      for (int b = 0; b < `WMASK_SIZE; b++) begin
         bits[LANE*b +: LANE] = {LANE{mask[b]}};
      end
      return bits;
   endfunction

   // Writes of one held instruction at one edge
   // Both merges start from the old words and port 0 lands last
   task automatic apply_writes(instr_t v);
      data_t new0;
      data_t new1;
      int    chip;
      chip = int'(v.chip_sel);
      new0 = (ref_mem[chip][v.port0.addr] & ~lane_bits(v.port0.wmask))
             | (v.port0.din & lane_bits(v.port0.wmask));
      new1 = (ref_mem[chip][v.port1.addr] & ~lane_bits(v.port1.wmask))
             | (v.port1.din & lane_bits(v.port1.wmask));
      if (!v.port1.csb && !v.port1.web) begin
         ref_mem[chip][v.port1.addr] = new1;
      end
      if (!v.port0.csb && !v.port0.web) begin
         ref_mem[chip][v.port0.addr] = new0;
      end
   endtask

   // Register after a capture of a read instruction
   function automatic instr_t predict_capture(instr_t v);
      instr_t p;
      p           = v;
      p.port0.din = ref_mem[v.chip_sel][v.port0.addr];
      p.port1.din = ref_mem[v.chip_sel][v.port1.addr];
      return p;
   endfunction

   `include "sram_test_tasks.svh"

   task automatic begin_test();
      first_error = error_count;
      first_check = check_count;
   endtask

   task automatic end_test(string name);
      test_count++;
      $display("%-22s checks %0d, errors %0d", name,
               check_count - first_check, error_count - first_error);
   endtask

   // Watchdog for the whole run
   initial begin
      #(RUN_LIMIT);
      $display("Simulation ran past its time limit and was stopped");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(50440));
      clk            = 1'b0;
      resetn         = 1'b0;
      in_select      = SRC_LA;
      la_in_load     = 1'b0;
      la_sram_load   = 1'b0;
      la_data_in     = '0;
      gpio_in        = 1'b0;
      gpio_scan      = 1'b0;
      gpio_sram_load = 1'b0;
      reg_model      = '0;
      error_count    = 0;
      check_count    = 0;
      test_count     = 0;
      repeat (2) @(posedge clk);
      #1;
      resetn = 1'b1;

      begin_test();
      reset_values();
      end_test("reset values");
      begin_test();
      parallel_load();
      end_test("parallel load");
      begin_test();
      full_mask_writes();
      end_test("full mask writes");
      begin_test();
      partial_mask_writes();
      end_test("partial mask writes");
      begin_test();
      gpio_scan_path();
      end_test("gpio scan path");

      $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sram_test.f
+incdir+hdl
+incdir+testbench
hdl/sram_port_pkg.sv
hdl/sram_test_pkg.sv
hdl/instr_register.sv
hdl/port_decode.sv
hdl/sram_macro_model.sv
hdl/sram_test_top.sv
testbench/sram_test_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SRAM test access testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module sram_test_tb \
   -Mdir "$BUILD_DIR" \
   -f sram_test.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

"./$BUILD_DIR/Vsram_test_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit "$status"
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
   echo "No result line found in $LOG"
   exit 1
fi
exit 0
